// ==== src/fpu_defs.svh ====
// width and bus count macros for the fpu operand path
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// data bits of one operand or result word
`define FPU_DATA_W 64

// data word plus one parity bit on top
`define FPU_WORD_W 65

// result buses that can be forwarded into the slot
`define FPU_NBUS 4

// one half of a word for the permute ops
`define FPU_HALF_W 32

// operands per issued op, A and B
`define FPU_NOPND 2

`endif

// ==== src/fpu_pkg.sv ====
// opcode enum, forwarding select, word, flag and retirement types
`include "fpu_defs.svh"

package fpu_pkg;

  // lane opcodes, unlisted codes give a zero result
  typedef enum logic [3:0] {
    op_and    = 4'd0,
    op_or     = 4'd1,
    op_xor    = 4'd2,
    op_andn   = 4'd3,
    op_cmp    = 4'd4,
    op_swap   = 4'd5,
    op_dup_lo = 4'd6,
    op_dup_hi = 4'd7,
    op_sel_b  = 4'd8
  } fpu_op_e;

  // one-hot bus select, one bit per result bus
  typedef logic [`FPU_NBUS-1:0] fpu_fwd_t;

  // data with parity in the top bit
  typedef logic [`FPU_WORD_W-1:0] fpu_word_t;

  // compare flags
  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } fpu_flags_t;

  // bit 0 parity error on A, bit 1 on B
  typedef logic [1:0] fpu_ret_t;

endpackage

// ==== src/fpu_issue.sv ====
// fpu_issue: result bus history and stage 1 opcode and valid registers
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_issue (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  op_valid,
  input  fpu_pkg::fpu_op_e                      op,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_word,
  output logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_now,
  output logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_prev,
  output logic                                  valid_s1,
  output fpu_pkg::fpu_op_e                      op_s1
);

  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_hist;

  // buses seen in the issue cycle itself
  assign bus_now = bus_word;

  // one-cycle-old copy of every bus, so a late consumer can still pick it up
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_hist <= '0;
    end else begin
      bus_hist <= bus_word;
    end
  end

  assign bus_prev = bus_hist;

  // op valid into stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= op_valid;
    end
  end

  // opcode travels alongside the valid
  always_ff @(posedge clk) begin
    op_s1 <= op;
  end

endmodule

// ==== src/fpu_operand_fwd.sv ====
// fpu_operand_fwd: picks one operand from the register word or a result bus
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_operand_fwd (
  input  logic                                  clk,
  input  logic                                  rst,
  input  fpu_pkg::fpu_word_t                    reg_word,
  input  fpu_pkg::fpu_fwd_t                     fwd_now,
  input  fpu_pkg::fpu_fwd_t                     fwd_prev,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_now,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_prev,
  output fpu_pkg::fpu_word_t                    opnd_s1,
  output logic                                  perr_s1
);

  fpu_pkg::fpu_word_t sel_word;
  logic               sel_bad;

  // walk from the top index down so the lowest set bit is the last to land;
  // the now pass runs after the prev pass and therefore overrides it
  always_comb begin
    sel_word = reg_word;
    for (int i = `FPU_NBUS - 1; i >= 0; i--) begin
      if (fwd_prev[i]) begin
        sel_word = bus_prev[i];
      end
    end
    for (int i = `FPU_NBUS - 1; i >= 0; i--) begin
      if (fwd_now[i]) begin
        sel_word = bus_now[i];
      end
    end
  end

  // even parity over data and parity bit
  assign sel_bad = ^sel_word;

  always_ff @(posedge clk) begin
    opnd_s1 <= sel_word;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      perr_s1 <= 1'b0;
    end else begin
      perr_s1 <= sel_bad;
    end
  end

endmodule

// ==== src/fpu_execute.sv ====
// fpu_execute: logic, compare and permute lane with result parity and retire code
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_execute (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   valid_s1,
  input  fpu_pkg::fpu_op_e                       op_s1,
  input  logic [`FPU_NOPND-1:0][`FPU_WORD_W-1:0] opnd_s1,
  input  logic [`FPU_NOPND-1:0]                  perr_s1,
  output logic                                   res_valid,
  output fpu_pkg::fpu_word_t                     res_word,
  output fpu_pkg::fpu_flags_t                    res_flags,
  output logic                                   ret_valid,
  output fpu_pkg::fpu_ret_t                      ret_code
);

  logic [`FPU_DATA_W-1:0] a_data;
  logic [`FPU_DATA_W-1:0] b_data;
  logic [`FPU_HALF_W-1:0] a_lo;
  logic [`FPU_HALF_W-1:0] a_hi;
  logic [`FPU_DATA_W-1:0] res_data;
  fpu_pkg::fpu_flags_t    cmp_flags;
  fpu_pkg::fpu_flags_t    op_flags;
  logic                   done_q;

  // parity bit stripped off
  assign a_data = opnd_s1[0][`FPU_DATA_W-1:0];
  assign b_data = opnd_s1[1][`FPU_DATA_W-1:0];

  assign a_lo = a_data[`FPU_HALF_W-1:0];
  assign a_hi = a_data[`FPU_DATA_W-1:`FPU_HALF_W];

  // flags for both orderings, only kept for op_cmp
  assign cmp_flags.eq  = (a_data == b_data);
  assign cmp_flags.lt  = ($signed(a_data) < $signed(b_data));
  assign cmp_flags.ltu = (a_data < b_data);

  always_comb begin
    res_data = '0;
    op_flags = '0;
    case (op_s1)
      fpu_pkg::op_and: begin
        res_data = a_data & b_data;
      end
      fpu_pkg::op_or: begin
        res_data = a_data | b_data;
      end
      fpu_pkg::op_xor: begin
        res_data = a_data ^ b_data;
      end
      fpu_pkg::op_andn: begin
        res_data = a_data & ~b_data;
      end
      fpu_pkg::op_cmp: begin
        // result word is just the signed less-than bit
        res_data[0] = cmp_flags.lt;
        op_flags    = cmp_flags;
      end
      fpu_pkg::op_swap: begin
        res_data = {a_lo, a_hi};
      end
      fpu_pkg::op_dup_lo: begin
        res_data = {a_lo, a_lo};
      end
      fpu_pkg::op_dup_hi: begin
        res_data = {a_hi, a_hi};
      end
      fpu_pkg::op_sel_b: begin
        res_data = b_data;
      end
      default: begin
        res_data = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= valid_s1;
    end
  end

  // fresh parity on the way out
  always_ff @(posedge clk) begin
    res_word  <= {^res_data, res_data};
    res_flags <= op_flags;
    ret_code  <= {perr_s1[1], perr_s1[0]};
  end

  // result and retirement leave together
  assign res_valid = done_q;
  assign ret_valid = done_q;

endmodule

// ==== src/fpu_unit.sv ====
// fpu_unit: issue stage, A and B operand forwarders and the execute lane
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_unit (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  op_valid,
  input  fpu_pkg::fpu_op_e                      op,
  input  fpu_pkg::fpu_word_t                    a_word,
  input  fpu_pkg::fpu_word_t                    b_word,
  input  fpu_pkg::fpu_fwd_t                     a_fwd_now,
  input  fpu_pkg::fpu_fwd_t                     a_fwd_prev,
  input  fpu_pkg::fpu_fwd_t                     b_fwd_now,
  input  fpu_pkg::fpu_fwd_t                     b_fwd_prev,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_word,
  output logic                                  res_valid,
  output fpu_pkg::fpu_word_t                    res_word,
  output fpu_pkg::fpu_flags_t                   res_flags,
  output logic                                  ret_valid,
  output fpu_pkg::fpu_ret_t                     ret_code
);

  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0]  bus_now;
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0]  bus_prev;
  logic                                   valid_s1;
  fpu_pkg::fpu_op_e                       op_s1;
  logic [`FPU_NOPND-1:0][`FPU_WORD_W-1:0] reg_words;
  logic [`FPU_NOPND-1:0][`FPU_NBUS-1:0]   fwd_now;
  logic [`FPU_NOPND-1:0][`FPU_NBUS-1:0]   fwd_prev;
  logic [`FPU_NOPND-1:0][`FPU_WORD_W-1:0] opnd_s1;
  logic [`FPU_NOPND-1:0]                  perr_s1;

  // index 0 is A, index 1 is B
  assign reg_words = {b_word, a_word};
  assign fwd_now   = {b_fwd_now, a_fwd_now};
  assign fwd_prev  = {b_fwd_prev, a_fwd_prev};

  fpu_issue u_issue (
    .clk      (clk),
    .rst      (rst),
    .op_valid (op_valid),
    .op       (op),
    .bus_word (bus_word),
    .bus_now  (bus_now),
    .bus_prev (bus_prev),
    .valid_s1 (valid_s1),
    .op_s1    (op_s1)
  );

  for (genvar g = 0; g < `FPU_NOPND; g++) begin : g_opnd
    fpu_operand_fwd u_fwd (
      .clk      (clk),
      .rst      (rst),
      .reg_word (reg_words[g]),
      .fwd_now  (fwd_now[g]),
      .fwd_prev (fwd_prev[g]),
      .bus_now  (bus_now),
      .bus_prev (bus_prev),
      .opnd_s1  (opnd_s1[g]),
      .perr_s1  (perr_s1[g])
    );
  end

  fpu_execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .valid_s1  (valid_s1),
    .op_s1     (op_s1),
    .opnd_s1   (opnd_s1),
    .perr_s1   (perr_s1),
    .res_valid (res_valid),
    .res_word  (res_word),
    .res_flags (res_flags),
    .ret_valid (ret_valid),
    .ret_code  (ret_code)
  );

endmodule

// ==== dv/fpu_unit_checks.sv ====
// checker for fpu_unit results, flags and retirement code against expected entries
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_unit_checks (
  input  logic                clk,
  input  logic                exp_valid,
  input  fpu_pkg::fpu_word_t  exp_word,
  input  fpu_pkg::fpu_flags_t exp_flags,
  input  fpu_pkg::fpu_ret_t   exp_code,
  input  logic                res_valid,
  input  fpu_pkg::fpu_word_t  res_word,
  input  fpu_pkg::fpu_flags_t res_flags,
  input  logic                ret_valid,
  input  fpu_pkg::fpu_ret_t   ret_code,
  output int                  error_count,
  output int                  check_count
);

  int errors = 0;
  int checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic report_mismatch(input string name, input logic [`FPU_WORD_W-1:0] got,
                                 input logic [`FPU_WORD_W-1:0] exp);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    assert (res_valid === exp_valid)
      else report_mismatch("res_valid", 65'(res_valid), 65'(exp_valid));
    assert (ret_valid === exp_valid)
      else report_mismatch("ret_valid", 65'(ret_valid), 65'(exp_valid));
    if (exp_valid === 1'b1) begin
      checks++;
      assert (res_word === exp_word)
        else report_mismatch("res_word", res_word, exp_word);
      assert (res_flags === exp_flags)
        else report_mismatch("res_flags", 65'(res_flags), 65'(exp_flags));
      assert (ret_code === exp_code)
        else report_mismatch("ret_code", 65'(ret_code), 65'(exp_code));
      // whole word must xor to zero
      assert (^res_word === 1'b0) else begin
        $display("result word %h at %0t carries a wrong parity bit", res_word, $time);
        errors++;
      end
    end
  end

endmodule

// ==== dv/tb_fpu_unit.sv ====
// testbench for fpu_unit: clock, reset, stimulus, reference queue and watchdog
`timescale 1ns/1ps
`include "fpu_defs.svh"

module tb_fpu_unit;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_DIRECTED    = 80;
  localparam int NUM_RANDOM      = 300;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * (NUM_DIRECTED + NUM_RANDOM) + 40;

  typedef struct {
    int                  due;
    fpu_pkg::fpu_word_t  word;
    fpu_pkg::fpu_flags_t flags;
    fpu_pkg::fpu_ret_t   code;
  } entry_t;

  logic                                  clk = 1'b0;
  logic                                  rst;
  logic                                  op_valid;
  fpu_pkg::fpu_op_e                      op;
  fpu_pkg::fpu_word_t                    a_word;
  fpu_pkg::fpu_word_t                    b_word;
  fpu_pkg::fpu_fwd_t                     a_fwd_now;
  fpu_pkg::fpu_fwd_t                     a_fwd_prev;
  fpu_pkg::fpu_fwd_t                     b_fwd_now;
  fpu_pkg::fpu_fwd_t                     b_fwd_prev;
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_word;
  logic                                  res_valid;
  fpu_pkg::fpu_word_t                    res_word;
  fpu_pkg::fpu_flags_t                   res_flags;
  logic                                  ret_valid;
  fpu_pkg::fpu_ret_t                     ret_code;

  // reference side
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] prev_bus;
  logic [`FPU_NBUS-1:0]                  bus_bad_mask;
  entry_t                                exp_q[$];
  logic                                  exp_valid;
  fpu_pkg::fpu_word_t                    exp_word;
  fpu_pkg::fpu_flags_t                   exp_flags;
  fpu_pkg::fpu_ret_t                     exp_code;
  int                                    cyc = 0;
  integer                                seed = 32'h60a49dce;
  int                                    errors;
  int                                    checks;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fpu_unit u_fpu_unit (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .op         (op),
    .a_word     (a_word),
    .b_word     (b_word),
    .a_fwd_now  (a_fwd_now),
    .a_fwd_prev (a_fwd_prev),
    .b_fwd_now  (b_fwd_now),
    .b_fwd_prev (b_fwd_prev),
    .bus_word   (bus_word),
    .res_valid  (res_valid),
    .res_word   (res_word),
    .res_flags  (res_flags),
    .ret_valid  (ret_valid),
    .ret_code   (ret_code)
  );

  fpu_unit_checks u_checks (
    .clk         (clk),
    .exp_valid   (exp_valid),
    .exp_word    (exp_word),
    .exp_flags   (exp_flags),
    .exp_code    (exp_code),
    .res_valid   (res_valid),
    .res_word    (res_word),
    .res_flags   (res_flags),
    .ret_valid   (ret_valid),
    .ret_code    (ret_code),
    .error_count (errors),
    .check_count (checks)
  );

  // present the entry that falls due on this edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    exp_valid = 1'b0;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      exp_valid = 1'b1;
      exp_word  = exp_q[0].word;
      exp_flags = exp_q[0].flags;
      exp_code  = exp_q[0].code;
      void'(exp_q.pop_front());
    end
  end

  function automatic fpu_pkg::fpu_word_t with_parity(input logic [`FPU_DATA_W-1:0] d);
    return {^d, d};
  endfunction

  function automatic fpu_pkg::fpu_word_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return with_parity({hi, lo});
  endfunction

  // lowest index wins, a current bus beats a captured one
  function automatic fpu_pkg::fpu_word_t pick_operand(input fpu_pkg::fpu_word_t reg_w,
                                                      input fpu_pkg::fpu_fwd_t now_sel,
                                                      input fpu_pkg::fpu_fwd_t prev_sel);
    fpu_pkg::fpu_word_t w;
    logic               found;
    w = reg_w;
    found = 1'b0;
    for (int i = 0; i < `FPU_NBUS; i++) begin
      if (!found && now_sel[i]) begin
        w = bus_word[i];
        found = 1'b1;
      end
    end
    for (int i = 0; i < `FPU_NBUS; i++) begin
      if (!found && prev_sel[i]) begin
        w = prev_bus[i];
        found = 1'b1;
      end
    end
    return w;
  endfunction

  function automatic entry_t model_op(input fpu_pkg::fpu_op_e o, input fpu_pkg::fpu_word_t aw,
                                      input fpu_pkg::fpu_word_t bw);
    entry_t                 e;
    logic [`FPU_DATA_W-1:0] a;
    logic [`FPU_DATA_W-1:0] b;
    logic [`FPU_DATA_W-1:0] d;
    a = aw[`FPU_DATA_W-1:0];
    b = bw[`FPU_DATA_W-1:0];
    d = '0;
    e.flags = '0;
    case (o)
      fpu_pkg::op_and:    d = a & b;
      fpu_pkg::op_or:     d = a | b;
      fpu_pkg::op_xor:    d = a ^ b;
      fpu_pkg::op_andn:   d = a & ~b;
      fpu_pkg::op_cmp: begin
        e.flags.eq  = (a == b);
        // sign bits differ, so the negative one is smaller
        e.flags.lt  = (a[63] != b[63]) ? a[63] : (a < b);
        e.flags.ltu = (a < b);
        d[0] = e.flags.lt;
      end
      fpu_pkg::op_swap:   d = {a[31:0], a[63:32]};
      fpu_pkg::op_dup_lo: d = {a[31:0], a[31:0]};
      fpu_pkg::op_dup_hi: d = {a[63:32], a[63:32]};
      fpu_pkg::op_sel_b:  d = b;
      default:            d = '0;
    endcase
    e.word = with_parity(d);
    e.code = {^bw, ^aw};
    e.due  = 0;
    return e;
  endfunction

  task automatic advance_bus();
    prev_bus = bus_word;
    for (int i = 0; i < `FPU_NBUS; i++) begin
      bus_word[i] = rand_word();
      if (bus_bad_mask[i]) begin
        bus_word[i][`FPU_DATA_W] = ~bus_word[i][`FPU_DATA_W];
      end
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    advance_bus();
    op_valid = 1'b0;
  endtask

  task automatic issue_op(input fpu_pkg::fpu_op_e o, input fpu_pkg::fpu_word_t aw,
                          input fpu_pkg::fpu_word_t bw, input fpu_pkg::fpu_fwd_t an,
                          input fpu_pkg::fpu_fwd_t ap, input fpu_pkg::fpu_fwd_t bn,
                          input fpu_pkg::fpu_fwd_t bp);
    entry_t e;
    @(negedge clk);
    advance_bus();
    op_valid   = 1'b1;
    op         = o;
    a_word     = aw;
    b_word     = bw;
    a_fwd_now  = an;
    a_fwd_prev = ap;
    b_fwd_now  = bn;
    b_fwd_prev = bp;
    e = model_op(o, pick_operand(aw, an, ap), pick_operand(bw, bn, bp));
    // sampled at the next edge, outputs update one edge later
    e.due = cyc + 2;
    exp_q.push_back(e);
  endtask

  task automatic issue_reg(input fpu_pkg::fpu_op_e o, input fpu_pkg::fpu_word_t aw,
                           input fpu_pkg::fpu_word_t bw);
    issue_op(o, aw, bw, 4'b0, 4'b0, 4'b0, 4'b0);
  endtask

  task automatic run_logic_ops();
    for (int k = 0; k < 4; k++) begin
      issue_reg(fpu_pkg::op_and, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_or, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_xor, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_andn, rand_word(), rand_word());
    end
  endtask

  task automatic compare_pair(input logic [`FPU_DATA_W-1:0] a, input logic [`FPU_DATA_W-1:0] b);
    issue_reg(fpu_pkg::op_cmp, with_parity(a), with_parity(b));
  endtask

  task automatic run_compare();
    compare_pair(64'h5, 64'h5);
    compare_pair({64{1'b1}}, 64'h1);
    compare_pair(64'h1, {64{1'b1}});
    compare_pair(64'h0, {64{1'b1}});
    compare_pair({64{1'b1}}, 64'h0);
    compare_pair({64{1'b1}}, {64{1'b1}});
    compare_pair(64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);
    compare_pair(64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
    compare_pair(64'h1234, 64'h1235);
  endtask

  task automatic run_permute();
    for (int k = 0; k < 3; k++) begin
      issue_reg(fpu_pkg::op_swap, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_dup_lo, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_dup_hi, rand_word(), rand_word());
      issue_reg(fpu_pkg::op_sel_b, rand_word(), rand_word());
    end
    issue_reg(fpu_pkg::fpu_op_e'(4'hc), rand_word(), rand_word());
  endtask

  task automatic run_forwarding();
    fpu_pkg::fpu_fwd_t onehot;
    for (int i = 0; i < `FPU_NBUS; i++) begin
      onehot = 4'b0001 << i;
      issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), onehot, 4'b0, 4'b0, 4'b0);
      issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, onehot, 4'b0, 4'b0);
      issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, 4'b0, onehot, 4'b0);
      issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, 4'b0, 4'b0, onehot);
    end
    // several bits set at once
    issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b1010, 4'b0111, 4'b0, 4'b0);
    issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, 4'b1100, 4'b0, 4'b0);
    issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, 4'b0, 4'b1111, 4'b1111);
    issue_op(fpu_pkg::op_xor, rand_word(), rand_word(), 4'b0, 4'b0, 4'b0, 4'b0110);
  endtask

  task automatic run_parity();
    fpu_pkg::fpu_word_t bad;
    bad = rand_word();
    bad[`FPU_DATA_W] = ~bad[`FPU_DATA_W];
    issue_reg(fpu_pkg::op_and, bad, rand_word());
    issue_reg(fpu_pkg::op_and, rand_word(), bad);
    issue_reg(fpu_pkg::op_or, bad, bad);
    // corrupt word on bus 2, then pick its captured copy
    bus_bad_mask = 4'b0100;
    issue_op(fpu_pkg::op_or, rand_word(), rand_word(), 4'b0100, 4'b0, 4'b0, 4'b0);
    bus_bad_mask = 4'b0000;
    issue_op(fpu_pkg::op_or, rand_word(), rand_word(), 4'b0, 4'b0, 4'b0, 4'b0100);
  endtask

  task automatic run_random();
    logic [31:0]        r;
    logic [31:0]        s;
    fpu_pkg::fpu_word_t aw;
    fpu_pkg::fpu_word_t bw;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      r = $random(seed);
      s = $random(seed);
      aw = rand_word();
      bw = rand_word();
      if (r[20:18] == 3'd0) aw[`FPU_DATA_W] = ~aw[`FPU_DATA_W];
      if (s[20:18] == 3'd0) bw[`FPU_DATA_W] = ~bw[`FPU_DATA_W];
      issue_op(fpu_pkg::fpu_op_e'(4'(r[31:24] % 8'd10)), aw, bw,
               r[3:0] & r[7:4] & {4{r[8]}}, r[12:9] & r[16:13] & {4{r[17]}},
               s[3:0] & s[7:4] & {4{s[8]}}, s[12:9] & s[16:13] & {4{s[17]}});
      if (s[31:30] == 2'b00) idle_cycle();
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    op_valid     = 1'b0;
    op           = fpu_pkg::op_and;
    a_word       = '0;
    b_word       = '0;
    a_fwd_now    = '0;
    a_fwd_prev   = '0;
    b_fwd_now    = '0;
    b_fwd_prev   = '0;
    bus_word     = '0;
    prev_bus     = '0;
    bus_bad_mask = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) idle_cycle();
    run_logic_ops();
    run_compare();
    run_permute();
    run_forwarding();
    run_parity();
    run_random();
    while (exp_q.size() != 0) idle_cycle();
    repeat (4) idle_cycle();
    $display("checked %0d results, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== fpu_unit.f ====
+incdir+src
src/fpu_pkg.sv
src/fpu_issue.sv
src/fpu_operand_fwd.sv
src/fpu_execute.sv
src/fpu_unit.sv
dv/fpu_unit_checks.sv
dv/tb_fpu_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the fpu_unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_fpu_unit \
  -f fpu_unit.f \
  --Mdir obj_dir

out=$(./obj_dir/Vtb_fpu_unit)
echo "$out"

if grep -qF "All tests passed!" <<< "$out"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
